// ==== compile.f ====
design/rv_isa_pkg.sv
design/core_pipe_pkg.sv
design/reg_file.sv
design/inst_decode.sv
design/alu_execute.sv
design/writeback_result.sv
design/rv_core_top.sv
sim/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
verilator --binary --timing --top-module tb_rv_core -f compile.f -o tb_rv_core \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_rv_core)
echo "$out"
echo "$out" | grep -qx '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sim/tb_rv_core.sv ====
// RV64 core testbench
`timescale 1ns/1ps
module tb_rv_core;

    localparam int          CLK_PERIOD = 10;
    localparam logic [31:0] SEED       = 32'h335b;
    localparam int N_SEED  = 62; // lui and addi per register
    localparam int N_RTYPE = 40;
    localparam int N_ITYPE = 16;
    localparam int N_CHAIN = 20;
    localparam int N_X0    = 5;
    localparam int N_GAP   = 5;
    localparam int N_END   = 4;
    localparam int N_TOTAL = N_SEED + N_RTYPE + N_ITYPE + N_CHAIN + N_X0 + N_GAP + N_END;
    localparam int WATCHDOG_CYCLES = 20 * N_TOTAL + 200;

    logic                   clk;
    logic                   rst_n_i;
    logic                   inst_valid_i;
    logic [31:0]            inst_i;
    core_pipe_pkg::commit_t commit_o;
    logic                   halt_o;

    core_pipe_pkg::commit_t exp_q [$]; // expected commits in issue order
    logic [63:0]            shadow [32];
    logic [63:0]            issue_pc;
    int                     n_checked = 0;

    rv_core_top u_rv_core_top (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .commit_o     (commit_o),
        .halt_o       (halt_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] act,
                             input logic [63:0] want);
        if (act !== want) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, act, want);
            stop_on_error();
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, rv_isa_pkg::OPC_LUI};
    endfunction

    function automatic logic [63:0] alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [63:0] a, input logic [63:0] b);
        logic [63:0] r;
        case (f3)
            rv_isa_pkg::F3_ADD:  r = alt ? a - b : a + b;
            rv_isa_pkg::F3_SLL:  r = a << b[5:0];
            rv_isa_pkg::F3_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            rv_isa_pkg::F3_SLTU: r = (a < b) ? 64'd1 : 64'd0;
            rv_isa_pkg::F3_XOR:  r = a ^ b;
            rv_isa_pkg::F3_SR: begin
                if (alt) r = $signed(a) >>> b[5:0];
                else     r = a >> b[5:0];
            end
            rv_isa_pkg::F3_OR:   r = a | b;
            default:             r = a & b;
        endcase
        return r;
    endfunction

    // expected commit of one word, shadow registers updated on a write
    function automatic core_pipe_pkg::commit_t ref_exec(input logic [31:0] word,
                                                        inout logic [63:0] regs [32],
                                                        input logic [63:0] pc);
        core_pipe_pkg::commit_t c;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [63:0] imm;
        logic        writes;
        f7     = word[31:25];
        f3     = word[14:12];
        imm    = {{52{word[31]}}, word[31:20]};
        writes = 1'b1;
        c         = '0;
        c.valid   = 1'b1;
        c.pc      = pc;
        c.rd      = word[11:7];
        if (word[6:0] == rv_isa_pkg::OPC_OP && (f7 == 7'b0 || f7 == rv_isa_pkg::F7_ALT)) begin
            c.wdata = alu_result(f3, f7 == rv_isa_pkg::F7_ALT, regs[word[19:15]],
                                 regs[word[24:20]]);
        end else if (word[6:0] == rv_isa_pkg::OPC_OP_IMM) begin
            c.wdata = alu_result(f3, f3 == rv_isa_pkg::F3_SR && word[30],
                                 regs[word[19:15]], imm); // no subi
        end else if (word[6:0] == rv_isa_pkg::OPC_LUI) begin
            c.wdata = {{32{word[31]}}, word[31:12], 12'h000};
        end else begin
            writes    = 1'b0;
            c.illegal = (word != rv_isa_pkg::EBREAK_WORD);
        end
        c.wen = writes && (c.rd != 5'd0);
        if (c.wen) begin
            regs[c.rd] = c.wdata;
        end
        return c;
    endfunction

    task automatic issue(input logic [31:0] word);
        @(posedge clk);
        #1;
        inst_valid_i = 1'b1;
        inst_i       = word;
        exp_q.push_back(ref_exec(word, shadow, issue_pc));
        issue_pc = issue_pc + 64'd4;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            inst_valid_i = 1'b0;
            inst_i       = '0;
        end
    endtask

    task automatic random_rtype(input logic [2:0] f3, input logic alt);
        logic [31:0] rnd;
        rnd = $urandom();
        issue(r_type(alt ? rv_isa_pkg::F7_ALT : 7'b0, rnd[14:10], rnd[9:5], f3, rnd[4:0]));
    endtask

    task automatic seed_regs();
        logic [31:0] rnd;
        for (int r = 1; r < 32; r++) begin
            rnd = $urandom();
            issue(lui_word(rnd[31:12], r[4:0]));
            issue(i_type(rnd[11:0], r[4:0], rv_isa_pkg::F3_ADD, r[4:0]));
        end
    endtask

    task automatic rtype_ops();
        logic [31:0] rnd;
        for (int i = 0; i < 8; i++) begin
            random_rtype(i[2:0], 1'b0);
        end
        random_rtype(rv_isa_pkg::F3_ADD, 1'b1); // sub
        random_rtype(rv_isa_pkg::F3_SR, 1'b1);  // sra
        for (int i = 0; i < 30; i++) begin
            rnd = $urandom();
            random_rtype(rnd[2:0], (rnd[2:0] == rv_isa_pkg::F3_ADD ||
                                    rnd[2:0] == rv_isa_pkg::F3_SR) && rnd[3]);
        end
    endtask

    task automatic itype_forms();
        logic [31:0] rnd;
        issue(lui_word(20'hf0f0f, 5'd5)); // negative source for the shifts
        for (int k = 0; k < 8; k++) begin
            if (k != 1 && k != 5) begin
                rnd = $urandom();
                issue(i_type({1'b1, rnd[10:0]}, rnd[15:11], k[2:0], {1'b1, rnd[19:16]}));
            end
        end
        // shamt 32 to 63, rd kept off x5
        for (int k = 0; k < 3; k++) begin
            rnd = $urandom();
            issue(i_type({6'b000000, 1'b1, rnd[4:0]}, 5'd5, rv_isa_pkg::F3_SLL,
                         {1'b1, rnd[8:5]}));
            issue(i_type({6'b000000, 1'b1, rnd[4:0]}, 5'd5, rv_isa_pkg::F3_SR,
                         {1'b1, rnd[12:9]}));
            issue(i_type({6'b010000, 1'b1, rnd[4:0]}, 5'd5, rv_isa_pkg::F3_SR,
                         {1'b1, rnd[16:13]}));
        end
    endtask

    task automatic dependent_chain();
        logic [31:0] rnd;
        logic [4:0]  rd;
        logic [4:0]  prev1;
        logic [4:0]  prev2;
        logic        alt;
        rd    = 5'd14;
        prev1 = 5'd10;
        prev2 = 5'd11;
        for (int k = 0; k < N_CHAIN; k++) begin
            rnd = $urandom();
            rd  = (rd == 5'd14) ? 5'd10 : rd + 5'd1; // x10..x14 in turn
            alt = (rnd[2:0] == rv_isa_pkg::F3_ADD || rnd[2:0] == rv_isa_pkg::F3_SR) && rnd[3];
            issue(r_type(alt ? rv_isa_pkg::F7_ALT : 7'b0, prev2, prev1, rnd[2:0], rd));
            prev2 = prev1;
            prev1 = rd;
        end
    endtask

    task automatic x0_writes();
        issue(i_type(12'd77, 5'd3, rv_isa_pkg::F3_ADD, 5'd0));
        issue(r_type(7'b0, 5'd5, 5'd4, rv_isa_pkg::F3_ADD, 5'd0));
        issue(lui_word(20'h12345, 5'd0));
        issue(r_type(7'b0, 5'd7, 5'd0, rv_isa_pkg::F3_ADD, 5'd6)); // x0 still reads zero
        issue(r_type(7'b0, 5'd0, 5'd0, rv_isa_pkg::F3_OR, 5'd8));
    endtask

    task automatic issue_gaps();
        issue(i_type(12'd1, 5'd1, rv_isa_pkg::F3_ADD, 5'd1));
        idle_cycles(3);
        issue(i_type(12'd2, 5'd1, rv_isa_pkg::F3_ADD, 5'd2));
        idle_cycles(1);
        issue(r_type(7'b0, 5'd2, 5'd1, rv_isa_pkg::F3_ADD, 5'd3));
        issue(r_type(rv_isa_pkg::F7_ALT, 5'd1, 5'd3, rv_isa_pkg::F3_ADD, 5'd4));
        idle_cycles(5);
        issue(r_type(7'b0, 5'd4, 5'd2, rv_isa_pkg::F3_XOR, 5'd5));
    endtask

    task automatic illegal_and_halt();
        issue(32'h0000_3083);                                        // ld, not supported
        issue(r_type(7'b0000001, 5'd2, 5'd1, rv_isa_pkg::F3_ADD, 5'd9)); // mul
        issue(32'h0000_0073);                                        // ecall
        idle_cycles(3); // let the illegal words commit first
        check_val("halt_o", 64'(halt_o), 64'd0);
        issue(rv_isa_pkg::EBREAK_WORD);
        idle_cycles(1);
    endtask

    // commit checker
    initial begin
        core_pipe_pkg::commit_t want;
        forever begin
            @(negedge clk);
            if (rst_n_i && commit_o.valid) begin
                if (exp_q.size() == 0) begin
                    $display("commit at pc %h arrived with nothing outstanding", commit_o.pc);
                    stop_on_error();
                end else begin
                    want = exp_q.pop_front();
                    check_val("commit_o.pc", commit_o.pc, want.pc);
                    check_val("commit_o.wen", 64'(commit_o.wen), 64'(want.wen));
                    check_val("commit_o.rd", 64'(commit_o.rd), 64'(want.rd));
                    check_val("commit_o.wdata", commit_o.wdata, want.wdata);
                    check_val("commit_o.illegal", 64'(commit_o.illegal), 64'(want.illegal));
                    n_checked++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired with %0d commits still outstanding", exp_q.size());
        stop_on_error();
    end

    initial begin
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        issue_pc     = core_pipe_pkg::RESET_PC;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        seed_regs();
        rtype_ops();
        itype_forms();
        dependent_chain();
        x0_writes();
        issue_gaps();
        illegal_and_halt();

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) begin
            @(negedge clk);
            check_val("halt_o", 64'(halt_o), 64'd1); // sticky after ebreak
        end

        if (n_checked != N_TOTAL || !halt_o) begin
            $display("run ended with %0d of %0d commits seen, halt_o %b",
                     n_checked, N_TOTAL, halt_o);
            stop_on_error();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== design/rv_core_top.sv ====
// RV64I core top level
`timescale 1ns/1ps
module rv_core_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   inst_valid_i,
    input  logic [31:0]            inst_i,
    output core_pipe_pkg::commit_t commit_o,
    output logic                   halt_o
);

    logic [core_pipe_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [core_pipe_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [core_pipe_pkg::XLEN-1:0]       rs1_data;
    logic [core_pipe_pkg::XLEN-1:0]       rs2_data;
    logic                                 wr_en;
    logic [core_pipe_pkg::REG_ADDR_W-1:0] wr_addr;
    logic [core_pipe_pkg::XLEN-1:0]       wr_data;
    core_pipe_pkg::dec_pkt_t              dec_pkt;
    core_pipe_pkg::exe_pkt_t              exe_comb; // alu output, not yet registered
    core_pipe_pkg::exe_pkt_t              exe_pkt;

    inst_decode u_inst_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .halt_i       (halt_o),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .exe_fwd_i    (exe_comb),
        .res_fwd_i    (exe_pkt), // packet being written back this cycle
        .dec_o        (dec_pkt)
    );

    alu_execute u_alu_execute (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .dec_i      (dec_pkt),
        .exe_comb_o (exe_comb),
        .exe_o      (exe_pkt)
    );

    writeback_result u_writeback_result (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .exe_i     (exe_pkt),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data),
        .commit_o  (commit_o),
        .halt_o    (halt_o)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data)
    );

endmodule

// ==== design/writeback_result.sv ====
// Result stage
`timescale 1ns/1ps
module writeback_result (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  core_pipe_pkg::exe_pkt_t              exe_i,
    output logic                                 wr_en_o,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0] wr_addr_o,
    output logic [core_pipe_pkg::XLEN-1:0]       wr_data_o,
    output core_pipe_pkg::commit_t               commit_o,
    output logic                                 halt_o
);

    // reg_wen already cleared for rd zero in decode
    assign wr_en_o   = exe_i.valid & exe_i.reg_wen;
    assign wr_addr_o = exe_i.rd;
    assign wr_data_o = exe_i.result;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_o <= '0;
            halt_o   <= 1'b0;
        end else begin
            commit_o <= '{
                valid:   exe_i.valid,
                pc:      exe_i.pc,
                rd:      exe_i.rd,
                wen:     exe_i.reg_wen,
                wdata:   exe_i.result, // zero for ebreak and illegal
                illegal: exe_i.illegal
            };
            if (exe_i.valid && exe_i.ebreak) begin
                halt_o <= 1'b1; // sticky until reset
            end
        end
    end

endmodule

// ==== design/alu_execute.sv ====
// Execute stage
`timescale 1ns/1ps
module alu_execute (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  core_pipe_pkg::dec_pkt_t dec_i,
    output core_pipe_pkg::exe_pkt_t exe_comb_o,
    output core_pipe_pkg::exe_pkt_t exe_o
);

    logic [core_pipe_pkg::XLEN-1:0] src1;
    logic [core_pipe_pkg::XLEN-1:0] src2;
    logic [5:0]                     shamt;
    logic [core_pipe_pkg::XLEN-1:0] alu_res;

    assign src1  = dec_i.src1;
    assign src2  = dec_i.src2;
    assign shamt = src2[5:0]; // rv64 shift range

    always_comb begin
        case (dec_i.alu_op)
            core_pipe_pkg::ALU_ADD:    alu_res = src1 + src2;
            core_pipe_pkg::ALU_SUB:    alu_res = src1 - src2;
            core_pipe_pkg::ALU_SLL:    alu_res = src1 << shamt;
            core_pipe_pkg::ALU_SLT:    alu_res = {63'b0, $signed(src1) < $signed(src2)};
            core_pipe_pkg::ALU_SLTU:   alu_res = {63'b0, src1 < src2};
            core_pipe_pkg::ALU_XOR:    alu_res = src1 ^ src2;
            core_pipe_pkg::ALU_SRL:    alu_res = src1 >> shamt;
            core_pipe_pkg::ALU_SRA:    alu_res = $signed(src1) >>> shamt;
            core_pipe_pkg::ALU_OR:     alu_res = src1 | src2;
            core_pipe_pkg::ALU_AND:    alu_res = src1 & src2;
            core_pipe_pkg::ALU_PASS_B: alu_res = src2;
            default:                   alu_res = '0;
        endcase
    end

    // also the youngest forwarding source for decode
    assign exe_comb_o = '{
        valid:   dec_i.valid,
        pc:      dec_i.pc,
        rd:      dec_i.rd,
        reg_wen: dec_i.reg_wen,
        result:  alu_res,
        ebreak:  dec_i.ebreak,
        illegal: dec_i.illegal
    };

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exe_o <= '0;
        end else begin
            exe_o <= exe_comb_o;
        end
    end

endmodule

// ==== design/inst_decode.sv ====
// Decode stage
`timescale 1ns/1ps
module inst_decode (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic                                     inst_valid_i,
    input  logic [31:0]                              inst_i,
    input  logic                                     halt_i,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0]     rs1_addr_o,
    output logic [core_pipe_pkg::REG_ADDR_W-1:0]     rs2_addr_o,
    input  logic [core_pipe_pkg::XLEN-1:0]           rs1_data_i,
    input  logic [core_pipe_pkg::XLEN-1:0]           rs2_data_i,
    input  core_pipe_pkg::exe_pkt_t                  exe_fwd_i,
    input  core_pipe_pkg::exe_pkt_t                  res_fwd_i,
    output core_pipe_pkg::dec_pkt_t                  dec_o
);

    rv_isa_pkg::rv_inst_u                inst;
    logic [core_pipe_pkg::XLEN-1:0]      pc_q;
    logic [core_pipe_pkg::XLEN-1:0]      imm_i;
    logic [core_pipe_pkg::XLEN-1:0]      imm_u;
    logic [core_pipe_pkg::XLEN-1:0]      imm;
    logic [core_pipe_pkg::XLEN-1:0]      rs1_val;
    logic [core_pipe_pkg::XLEN-1:0]      rs2_val;
    core_pipe_pkg::alu_op_e              alu_op;
    logic                                use_imm;
    logic                                reg_wen;
    logic                                is_ebreak;
    logic                                illegal;
    logic                                accept;

    function automatic core_pipe_pkg::alu_op_e f3_to_op(input logic [2:0] funct3,
                                                        input logic alt);
        core_pipe_pkg::alu_op_e op;
        op = core_pipe_pkg::ALU_ADD;
        case (funct3)
            rv_isa_pkg::F3_ADD:  op = alt ? core_pipe_pkg::ALU_SUB : core_pipe_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:  op = core_pipe_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  op = core_pipe_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: op = core_pipe_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  op = core_pipe_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:   op = alt ? core_pipe_pkg::ALU_SRA : core_pipe_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   op = core_pipe_pkg::ALU_OR;
            rv_isa_pkg::F3_AND:  op = core_pipe_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // youngest producer wins, register file last
    function automatic logic [core_pipe_pkg::XLEN-1:0] fwd_sel(
        input logic [core_pipe_pkg::REG_ADDR_W-1:0] addr,
        input logic [core_pipe_pkg::XLEN-1:0]       rf_data,
        input core_pipe_pkg::exe_pkt_t              exe_p,
        input core_pipe_pkg::exe_pkt_t              res_p
    );
        if (exe_p.valid && exe_p.reg_wen && exe_p.rd != '0 && exe_p.rd == addr)
            return exe_p.result;
        else if (res_p.valid && res_p.reg_wen && res_p.rd != '0 && res_p.rd == addr)
            return res_p.result;
        else
            return rf_data;
    endfunction

    assign inst       = inst_i;
    assign accept     = inst_valid_i & ~halt_i; // no new work after halt
    assign rs1_addr_o = inst.r.rs1;
    assign rs2_addr_o = inst.r.rs2;

    assign imm_i = {{52{inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_u = {{32{inst.i.imm12[11]}}, inst.i.imm12, inst.i.rs1, inst.i.funct3, 12'b0};

    assign rs1_val = fwd_sel(inst.r.rs1, rs1_data_i, exe_fwd_i, res_fwd_i);
    assign rs2_val = fwd_sel(inst.r.rs2, rs2_data_i, exe_fwd_i, res_fwd_i);

    always_comb begin
        alu_op    = core_pipe_pkg::ALU_PASS_B;
        imm       = '0; // pass-b of zero for ebreak and illegal
        use_imm   = 1'b1;
        reg_wen   = 1'b0;
        is_ebreak = 1'b0;
        illegal   = 1'b0;
        case (inst.r.opcode)
            rv_isa_pkg::OPC_OP: begin
                if (inst.r.funct7 == 7'b0 || inst.r.funct7 == rv_isa_pkg::F7_ALT) begin
                    alu_op  = f3_to_op(inst.r.funct3, inst.r.funct7 == rv_isa_pkg::F7_ALT);
                    use_imm = 1'b0;
                    reg_wen = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                // bit 30 picks srai, no subi exists
                alu_op  = f3_to_op(inst.i.funct3,
                                   inst.i.funct3 == rv_isa_pkg::F3_SR && inst.i.imm12[10]);
                imm     = imm_i;
                reg_wen = 1'b1;
            end
            rv_isa_pkg::OPC_LUI: begin
                imm     = imm_u;
                reg_wen = 1'b1;
            end
            rv_isa_pkg::OPC_SYSTEM: begin
                if (inst_i == rv_isa_pkg::EBREAK_WORD) is_ebreak = 1'b1;
                else                                   illegal   = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q  <= core_pipe_pkg::RESET_PC;
            dec_o <= '0;
        end else begin
            if (accept) pc_q <= pc_q + 64'd4;
            dec_o.valid   <= accept;
            dec_o.pc      <= pc_q;
            dec_o.alu_op  <= alu_op;
            dec_o.src1    <= rs1_val;
            dec_o.src2    <= use_imm ? imm : rs2_val;
            dec_o.rd      <= inst.r.rd;
            dec_o.reg_wen <= reg_wen & (inst.r.rd != '0); // x0 never written
            dec_o.ebreak  <= is_ebreak;
            dec_o.illegal <= illegal;
        end
    end

endmodule

// ==== design/reg_file.sv ====
// Integer register file
`timescale 1ns/1ps
module reg_file (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic [core_pipe_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [core_pipe_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [core_pipe_pkg::XLEN-1:0]       rs1_data_o,
    output logic [core_pipe_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                                 wr_en_i,
    input  logic [core_pipe_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [core_pipe_pkg::XLEN-1:0]       wr_data_i
);

    logic [core_pipe_pkg::XLEN-1:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // no write-through, decode forwarding covers it
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== design/core_pipe_pkg.sv ====
// Pipeline types and constants
package core_pipe_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // lui, also zero result for ebreak and illegal
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       src1;
        logic [XLEN-1:0]       src2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        logic                  ebreak;
        logic                  illegal;
    } dec_pkt_t;

    // execute to result
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        logic [XLEN-1:0]       result;
        logic                  ebreak;
        logic                  illegal;
    } exe_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       wdata;
        logic                  illegal;
    } commit_t;

endpackage

// ==== design/rv_isa_pkg.sv ====
// RV64I instruction encoding
package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 for integer ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl and sra share this
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000; // sub, sra

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    // one word, two field layouts
    typedef union packed {
        rv_r_fmt_t r;
        rv_i_fmt_t i;
    } rv_inst_u;

endpackage
